// ==== include/caster_consts.svh ====
`ifndef CASTER_CONSTS_SVH
`define CASTER_CONSTS_SVH

// frame buffer geometry
`define SCREEN_WIDTH 320        // columns per row, also the address stride
`define SCREEN_HEIGHT 180       // rows per column
`define HALF_SCREEN_HEIGHT 90   // horizon row

// 8 bit palette entries
`define SKY_COLOR 8'h2a         // sky blue
`define GROUND_COLOR 8'hdc      // brown floor
`define BLACK_WALL_COLOR 8'hff
`define GREEN_WALL_COLOR 8'h97

// field widths
`define HCOUNT_W 9              // enough for 0..319
`define ROW_W 8                 // enough for 0..179
`define HEIGHT_W 8
`define MAP_W 4
`define ADDR_W 16               // 320*180 pixels fit in 16 bits
`define COLOR_W 8

`endif

// ==== hdl/caster_pkg.sv ====
`default_nettype none

`include "caster_consts.svh"

package caster_pkg;

    // one column record from the ray marcher
    typedef struct packed {
        logic [`HCOUNT_W-1:0] hcount;      // screen column
        logic [`HEIGHT_W-1:0] line_height; // projected wall height in rows
        logic wall_type;                   // 0 = x face, 1 = y face
        logic [`MAP_W-1:0] map_data;       // map cell value
    } column_rec_t;

    // wall span, rows [draw_start, draw_end)
    typedef struct packed {
        logic [`ROW_W-1:0] draw_start;     // first wall row
        logic [`ROW_W-1:0] draw_end;       // first floor row
    } span_t;

    // one step of the row sweep
    typedef struct packed {
        logic [`ROW_W-1:0] row;
        logic [`ADDR_W-1:0] addr;          // hcount + row*width
        logic last_row;                    // row 179 of a packet-last column
        logic valid;
    } row_ctx_t;

    // frame buffer write
    typedef struct packed {
        logic valid;
        logic [`ADDR_W-1:0] addr;
        logic shade;                       // darken this pixel (y face)
        logic [`COLOR_W-1:0] color;
        logic last_pixel;                  // frame done, buffer may swap
    } pixel_wr_t;

endpackage

`default_nettype wire

// ==== hdl/column_intake.sv ====
`timescale 1ns/100ps
`default_nettype none

module column_intake (
    input  logic                    pixel_clk_in,
    input  logic                    rst_in,
    input  logic                    rec_valid,
    input  caster_pkg::column_rec_t rec,
    input  logic                    rec_last,
    input  logic                    fb_swap_ok,
    input  logic                    sweep_done,
    output logic                    rec_ready,
    output caster_pkg::column_rec_t cur_rec,
    output logic                    cur_last,
    output logic                    start
);

    typedef enum logic [1:0] {
        wait_column,    // ready high, waiting for a record
        sweeping,       // column in flight
        wait_swap       // packet done, frame buffer not swapped yet
    } intake_state_t;

    intake_state_t state;
    logic accept;

    assign accept = rec_valid && rec_ready; // handshake edge

    // record payload, only loaded on accept
    always_ff @(posedge pixel_clk_in) begin
        if (accept) begin
            cur_rec <= rec;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            state <= wait_column;
            rec_ready <= 1'b1;
            cur_last <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0; // single cycle pulse
            case (state)
                wait_column: begin
                    if (accept) begin
                        cur_last <= rec_last;
                        rec_ready <= 1'b0; // one column at a time
                        start <= 1'b1;
                        state <= sweeping;
                    end
                end
                sweeping: begin
                    if (sweep_done) begin
                        if (cur_last) begin
                            state <= wait_swap; // hold off until the swap
                        end else begin
                            rec_ready <= 1'b1;
                            state <= wait_column;
                        end
                    end
                end
                wait_swap: begin
                    // level from frame buffer, ready follows a cycle later
                    if (fb_swap_ok) begin
                        rec_ready <= 1'b1;
                        state <= wait_column;
                    end
                end
                default: state <= wait_column;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/span_calc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "caster_consts.svh"

module span_calc (
    input  logic                      pixel_clk_in,
    input  logic                      rst_in,
    input  logic                      start,
    input  logic [`HEIGHT_W-1:0]      line_height,
    output caster_pkg::span_t         span
);

    logic [`HEIGHT_W-1:0] half_raw;
    logic [`HEIGHT_W-1:0] half_sat;

    assign half_raw = line_height >> 1;
    // tall walls fill the screen, clamp to the horizon distance
    assign half_sat = (half_raw > `HEIGHT_W'(`HALF_SCREEN_HEIGHT))
                    ? `HEIGHT_W'(`HALF_SCREEN_HEIGHT) : half_raw;

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            span <= '0;
        end else if (start) begin // held for the whole sweep
            span.draw_start <= `ROW_W'(`HALF_SCREEN_HEIGHT) - `ROW_W'(half_sat);
            span.draw_end <= `ROW_W'(`HALF_SCREEN_HEIGHT) + `ROW_W'(half_sat); // max 180
        end
    end

endmodule

`default_nettype wire

// ==== hdl/row_sweeper.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "caster_consts.svh"

module row_sweeper (
    input  logic                      pixel_clk_in,
    input  logic                      rst_in,
    input  logic                      start,
    input  logic [`HCOUNT_W-1:0]      hcount,
    input  logic                      last_column,
    output caster_pkg::row_ctx_t      row,
    output logic                      sweep_done
);

    logic active;
    logic [`ROW_W-1:0] row_cnt;
    logic [`ADDR_W-1:0] addr;
    logic last_row;
    logic at_penult; // next row is the final one

    assign at_penult = (row_cnt == `ROW_W'(`SCREEN_HEIGHT - 2));

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            active <= 1'b0;
            row_cnt <= '0;
            last_row <= 1'b0;
            sweep_done <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
            row_cnt <= '0;
            last_row <= 1'b0;
            sweep_done <= 1'b0;
        end else if (active) begin
            if (row_cnt == `ROW_W'(`SCREEN_HEIGHT - 1)) begin
                active <= 1'b0; // column finished
                sweep_done <= 1'b0;
                last_row <= 1'b0;
            end else begin
                row_cnt <= row_cnt + 1'b1;
                sweep_done <= at_penult; // lines up with row 179
                last_row <= at_penult && last_column;
            end
        end
    end

    // running address, one add per row instead of row*width
    always_ff @(posedge pixel_clk_in) begin
        if (start) begin
            addr <= `ADDR_W'(hcount);
        end else if (active) begin
            addr <= addr + `ADDR_W'(`SCREEN_WIDTH);
        end
    end

    assign row = '{row: row_cnt, addr: addr, last_row: last_row, valid: active};

endmodule

`default_nettype wire

// ==== hdl/pixel_shader.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "caster_consts.svh"

module pixel_shader (
    input  logic                      pixel_clk_in,
    input  logic                      rst_in,
    input  caster_pkg::row_ctx_t      row,
    input  caster_pkg::span_t         span,
    input  logic [`MAP_W-1:0]         map_data,
    input  logic                      wall_type,
    output caster_pkg::pixel_wr_t     pix
);

    typedef enum logic [1:0] {
        region_ceiling,
        region_floor,
        region_wall
    } region_t;

    region_t region;
    logic [`COLOR_W-1:0] color_next;
    logic shade_next;
    logic valid_q;
    logic last_q;
    logic [`ADDR_W-1:0] addr_q;
    logic [`COLOR_W-1:0] color_q;
    logic shade_q;

    always_comb begin
        if (row.row < span.draw_start) begin
            region = region_ceiling;
        end else if (row.row >= span.draw_end) begin
            region = region_floor;
        end else begin
            region = region_wall;
        end
    end

    always_comb begin
        shade_next = 1'b0; // only plain walls get shaded
        case (region)
            region_ceiling: color_next = `SKY_COLOR;
            region_floor:   color_next = `GROUND_COLOR;
            default: begin
                case (map_data)
                    `MAP_W'd1: begin
                        color_next = `BLACK_WALL_COLOR;
                        shade_next = wall_type;
                    end
                    `MAP_W'd2: begin
                        color_next = `GREEN_WALL_COLOR;
                        shade_next = wall_type;
                    end
                    default: color_next = `SKY_COLOR; // empty or unused cell
                endcase
            end
        endcase
    end

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end else begin
            valid_q <= row.valid;
            last_q <= row.last_row;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        addr_q <= row.addr;
        color_q <= color_next;
        shade_q <= shade_next;
    end

    assign pix = '{valid: valid_q, addr: addr_q, shade: shade_q, color: color_q,
                   last_pixel: last_q};

endmodule

`default_nettype wire

// ==== hdl/column_flattener.sv ====
`timescale 1ns/100ps
`default_nettype none

module column_flattener (
    input  logic                      pixel_clk_in,
    input  logic                      rst_in,
    input  logic                      rec_valid,
    input  caster_pkg::column_rec_t   rec,
    input  logic                      rec_last,
    input  logic                      fb_swap_ok,
    output logic                      rec_ready,
    output caster_pkg::pixel_wr_t     pix
);

    caster_pkg::column_rec_t cur_rec; // record being drawn
    caster_pkg::span_t span;
    caster_pkg::row_ctx_t row;
    logic cur_last;
    logic start;
    logic sweep_done;

    column_intake u_intake (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .rec_valid    (rec_valid),
        .rec          (rec),
        .rec_last     (rec_last),
        .fb_swap_ok   (fb_swap_ok),
        .sweep_done   (sweep_done),
        .rec_ready    (rec_ready),
        .cur_rec      (cur_rec),
        .cur_last     (cur_last),
        .start        (start)
    );

    // span and sweeper both kick off on start
    span_calc u_span (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .start        (start),
        .line_height  (cur_rec.line_height),
        .span         (span)
    );

    row_sweeper u_sweeper (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .start        (start),
        .hcount       (cur_rec.hcount),
        .last_column  (cur_last),
        .row          (row),
        .sweep_done   (sweep_done)
    );

    pixel_shader u_shader (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .row          (row),
        .span         (span),
        .map_data     (cur_rec.map_data),
        .wall_type    (cur_rec.wall_type),
        .pix          (pix)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic pixel_clk_in,
    output logic rst_in
);

    initial begin
        pixel_clk_in = 1'b0;
        forever #2 pixel_clk_in = ~pixel_clk_in; // 4 ns period
    end

    initial begin
        rst_in = 1'b1;
        repeat (16) @(posedge pixel_clk_in);
        rst_in <= 1'b0; // released on an edge, like the design expects
    end

endmodule

`default_nettype wire

// ==== verif/flattener_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module flattener_checker (
    input logic                      pixel_clk_in,
    input logic                      rst_in,
    input logic                      rec_valid,
    input caster_pkg::column_rec_t   rec,
    input logic                      rec_last,
    input logic                      rec_ready,
    input caster_pkg::pixel_wr_t     pix
);

    // a stalled record has to sit still until it is taken
    rec_stable_a: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        rec_valid && !rec_ready |=> $stable(rec) && $stable(rec_last))
        else $error("rec or rec_last changed while stalled");

    last_valid_a: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        pix.last_pixel |-> pix.valid)
        else $error("pix.last_pixel high without pix.valid");

    // ready may come back on the final pixel, so look one cycle on
    ready_idle_a: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        rec_ready && $past(rec_ready) |-> !pix.valid)
        else $error("pixel written while rec_ready was high");

endmodule

bind column_flattener flattener_checker u_checker (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .rec_valid    (rec_valid),
    .rec          (rec),
    .rec_last     (rec_last),
    .rec_ready    (rec_ready),
    .pix          (pix)
);

`default_nettype wire

// ==== verif/column_flattener_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "caster_consts.svh"

module column_flattener_tb;

    localparam int num_columns = 40;
    localparam int reset_timeout = 64;
    localparam int ready_timeout = 2000;  // a long swap wait fits easily
    localparam int drain_timeout = 4000;

    logic pixel_clk_in;
    logic rst_in;
    logic rec_valid;
    caster_pkg::column_rec_t rec;
    logic rec_last;
    logic fb_swap_ok;
    logic rec_ready;
    caster_pkg::pixel_wr_t pix;

    logic [31:0] lcg_state = 32'd18; // fixed seed

    // model state, advanced on the falling edge
    caster_pkg::pixel_wr_t exp_q[$];  // one entry per cycle of the column
    caster_pkg::pixel_wr_t exp_now;
    logic exp_ready;
    logic col_last;                   // packet-last flag of the column in flight
    logic waiting_swap;
    int ready_count;                  // edges left until the sweep ends
    int pix_count;
    int cols_done;
    int row_idx;

    tb_clock_gen u_clk (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in)
    );

    column_flattener i_dut (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .rec_valid    (rec_valid),
        .rec          (rec),
        .rec_last     (rec_last),
        .fb_swap_ok   (fb_swap_ok),
        .rec_ready    (rec_ready),
        .pix          (pix)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_with_failure($sformatf("Fail at %0t: %s is %0h, expected %0h",
                                    $time, name, got, exp));
    endtask

    task automatic check_pixel(input caster_pkg::pixel_wr_t got,
                               input caster_pkg::pixel_wr_t exp);
        if (got.valid !== exp.valid) begin
            report_mismatch("pix.valid", 32'(got.valid), 32'(exp.valid));
        end else if (got.last_pixel !== exp.last_pixel) begin
            report_mismatch("pix.last_pixel", 32'(got.last_pixel), 32'(exp.last_pixel));
        end else if (exp.valid) begin // payload only matters on a write
            if (got.addr !== exp.addr) begin
                report_mismatch("pix.addr", 32'(got.addr), 32'(exp.addr));
            end else if (got.color !== exp.color) begin
                report_mismatch("pix.color", 32'(got.color), 32'(exp.color));
            end else if (got.shade !== exp.shade) begin
                report_mismatch("pix.shade", 32'(got.shade), 32'(exp.shade));
            end
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch("rec_ready", 32'(got), 32'(exp));
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'd0, lcg_state[31:16]}; // upper half, low bits repeat too fast
    endfunction

    function automatic caster_pkg::column_rec_t random_record();
        caster_pkg::column_rec_t r;
        logic [31:0] rnd;
        r.hcount = `HCOUNT_W'(next_random() % `SCREEN_WIDTH);
        r.line_height = `HEIGHT_W'(next_random()); // 0..255, over 180 saturates
        rnd = next_random();
        r.wall_type = rnd[8];
        if (rnd[3]) begin
            r.map_data = rnd[0] ? `MAP_W'd2 : `MAP_W'd1; // extra weight on real walls
        end else begin
            r.map_data = rnd[7:4];
        end
        return r;
    endfunction

    // expected write for one row, straight from the span and color rules
    function automatic caster_pkg::pixel_wr_t model_pixel(input caster_pkg::column_rec_t r,
                                                          input logic last, input int row);
        caster_pkg::pixel_wr_t p;
        int half;
        int wall_top;
        int floor_top;
        half = int'(r.line_height) / 2;
        if (half > `HALF_SCREEN_HEIGHT) begin
            half = `HALF_SCREEN_HEIGHT;
        end
        wall_top = `HALF_SCREEN_HEIGHT - half;
        floor_top = `HALF_SCREEN_HEIGHT + half;
        p.valid = 1'b1;
        p.addr = `ADDR_W'(int'(r.hcount) + row * `SCREEN_WIDTH);
        p.last_pixel = last && (row == `SCREEN_HEIGHT - 1);
        p.shade = 1'b0;
        if (row < wall_top) begin
            p.color = `SKY_COLOR;
        end else if (row >= floor_top) begin
            p.color = `GROUND_COLOR;
        end else if (r.map_data == `MAP_W'd1) begin
            p.color = `BLACK_WALL_COLOR;
            p.shade = r.wall_type;
        end else if (r.map_data == `MAP_W'd2) begin
            p.color = `GREEN_WALL_COLOR;
            p.shade = r.wall_type;
        end else begin
            p.color = `SKY_COLOR; // empty cell and unused values
        end
        return p;
    endfunction

    // next rising edge, with a fresh swap level from the frame buffer side
    task automatic tick();
        @(posedge pixel_clk_in);
        fb_swap_ok <= (next_random() % 6) == 0;
    endtask

    task automatic send_column(input caster_pkg::column_rec_t r, input logic last);
        int waited;
        logic [31:0] junk;
        rec_valid <= 1'b1;
        rec <= r;
        rec_last <= last;
        waited = 0;
        @(negedge pixel_clk_in);
        while (!rec_ready) begin
            if (waited == ready_timeout) begin
                stop_with_failure("rec_ready stayed low, the record was never accepted");
            end
            tick();
            waited++;
            @(negedge pixel_clk_in);
        end
        tick(); // handshake edge
        junk = next_random() << 16;
        junk = junk | next_random();
        rec_valid <= 1'b0;
        rec <= caster_pkg::column_rec_t'(junk[21:0]); // garbage the DUT must ignore
        rec_last <= junk[31];
    endtask

    always @(negedge pixel_clk_in) begin
        if (rst_in) begin
            exp_q.delete();
            exp_ready = 1'b1;
            waiting_swap = 1'b0;
            ready_count = 0;
            pix_count = 0;
            cols_done = 0;
            col_last = 1'b0;
        end else begin
            if (exp_q.size() > 0) begin
                exp_now = exp_q.pop_front();
            end else begin
                exp_now = caster_pkg::pixel_wr_t'(0); // idle, no write
            end
            check_ready(rec_ready, exp_ready);
            check_pixel(pix, exp_now);
            if (exp_now.valid) begin
                pix_count++;
                if (pix_count == `SCREEN_HEIGHT) begin
                    cols_done++;
                    pix_count = 0;
                end
            end
            // ready level for the next cycle
            if (waiting_swap) begin
                if (fb_swap_ok) begin
                    exp_ready = 1'b1;
                    waiting_swap = 1'b0;
                end
            end else if (ready_count > 0) begin
                ready_count--;
                if (ready_count == 0) begin
                    if (col_last) begin
                        waiting_swap = 1'b1; // frame end, hold for the swap
                    end else begin
                        exp_ready = 1'b1;    // back with the final pixel
                    end
                end
            end else if (rec_valid && rec_ready) begin
                if (exp_q.size() != 0) begin
                    stop_with_failure("a record was accepted while a column was being drawn");
                end
                exp_ready = 1'b0;
                col_last = rec_last;
                ready_count = `SCREEN_HEIGHT + 1; // accept edge to sweep_done edge
                exp_q.push_back(caster_pkg::pixel_wr_t'(0)); // start pulse
                exp_q.push_back(caster_pkg::pixel_wr_t'(0)); // row 0 in the sweeper
                for (row_idx = 0; row_idx < `SCREEN_HEIGHT; row_idx++) begin
                    exp_q.push_back(model_pixel(rec, rec_last, row_idx));
                end
            end
        end
    end

    initial begin
        caster_pkg::column_rec_t r;
        logic last;
        logic drained;
        int waited;
        int gap;
        int n;
        rec_valid <= 1'b0;
        rec <= '0;
        rec_last <= 1'b0;
        fb_swap_ok <= 1'b0;
        waited = 0;
        @(negedge pixel_clk_in);
        while (rst_in) begin
            if (waited == reset_timeout) begin
                stop_with_failure("reset was never released");
            end
            @(negedge pixel_clk_in);
            waited++;
        end
        for (n = 0; n < num_columns; n++) begin
            tick();
            gap = int'(next_random() % 4);
            repeat (gap) tick(); // idle between records
            r = random_record();
            last = (n == num_columns - 1) || ((next_random() % 4) == 0); // frame ends last
            send_column(r, last);
        end
        waited = 0;
        drained = 1'b0;
        while (!drained) begin
            if (waited == drain_timeout) begin
                stop_with_failure("the final columns never finished drawing");
            end
            tick();
            drained = (cols_done == num_columns); // model counters only move on negedge
            @(negedge pixel_clk_in);
            drained = drained && rec_ready;
            waited++;
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
hdl/caster_pkg.sv
hdl/column_intake.sv
hdl/span_calc.sv
hdl/row_sweeper.sv
hdl/pixel_shader.sv
hdl/column_flattener.sv
verif/tb_clock_gen.sv
verif/flattener_checker.sv
verif/column_flattener_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = column_flattener_tb
FILELIST   = files.f
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
